/* Makefile */
SIM      := verilator
FLAGS    := --binary --assert -j 0
TOP      := axis_in_tb
FILELIST := axis_in.f
OBJ_DIR  := obj_dir
LOG      := sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* axis_in.f */
logic/axis_in_pkg.sv
logic/lane_ram.sv
logic/axis_lane_packer.sv
logic/word_fifo_ctrl.sv
logic/axis_in_csr.sv
logic/axis_in_top.sv
tb/axis_in_tb.sv

/* logic/axis_in_csr.sv */
/*
 * Control and status registers of the stream input core
 * Output steering by mode, DATA pops and the level interrupt
 */
`timescale 1ns/100ps
`default_nettype none

module axis_in_csr (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  logic                              csr_wen_i,
   input  logic                              csr_ren_i,
   input  logic [axis_in_pkg::CSR_ADDR_W-1:0] csr_addr_i,
   input  logic [axis_in_pkg::DATA_W-1:0]     csr_wdata_i,
   input  logic                              out_valid_i,
   input  logic [axis_in_pkg::DATA_W-1:0]     out_data_i,
   input  logic                              empty_i,
   input  logic                              full_i,
   input  logic [axis_in_pkg::LEVEL_W-1:0]    level_i,
   input  logic                              tlast_detected_i,
   input  logic [axis_in_pkg::DATA_W-1:0]     nbeats_i,
   input  logic                              sys_tready_i,
   output logic [axis_in_pkg::DATA_W-1:0]     csr_rdata_o,
   output logic                              enable_o,
   output logic                              stream_mode_o,
   output logic                              soft_rst_o,
   output logic                              pop_o,
   output logic                              sys_tvalid_o,
   output logic [axis_in_pkg::DATA_W-1:0]     sys_tdata_o,
   output logic                              interrupt_o
);

   import axis_in_pkg::*;

   logic               enable_q;
   logic               mode_q;
   logic               srst_q;
   logic [LEVEL_W-1:0] thresh_q;
   logic               data_rd;
   logic [DATA_W-1:0]  ctrl_word;
   logic [DATA_W-1:0]  status_word;
   logic [DATA_W-1:0]  rdata_nxt;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         enable_q <= 1'b0;
         mode_q   <= 1'b0;
         srst_q   <= 1'b0;
         // Out of reach until software programs it
         thresh_q <= '1;
      end else if (csr_wen_i) begin
         if (csr_addr_i == REG_CTRL) begin
            enable_q <= csr_wdata_i[CTRL_EN_BIT];
            mode_q   <= csr_wdata_i[CTRL_MODE_BIT];
            srst_q   <= csr_wdata_i[CTRL_SRST_BIT];
         end
         if (csr_addr_i == REG_THRESH) begin
            thresh_q <= csr_wdata_i[LEVEL_W-1:0];
         end
      end
   end

   assign enable_o      = enable_q;
   assign stream_mode_o = mode_q;
   assign soft_rst_o    = srst_q;

   // DATA reads only consume words in CSR mode
   assign data_rd = csr_ren_i & (csr_addr_i == REG_DATA) & ~mode_q & out_valid_i;
   assign pop_o   = mode_q ? (sys_tready_i & out_valid_i) : data_rd;

   assign sys_tvalid_o = out_valid_i & mode_q;
   assign sys_tdata_o  = out_data_i;

   assign interrupt_o = (level_i >= thresh_q);

   always_comb begin
      ctrl_word                   = '0;
      ctrl_word[CTRL_EN_BIT]      = enable_q;
      ctrl_word[CTRL_MODE_BIT]    = mode_q;
      ctrl_word[CTRL_SRST_BIT]    = srst_q;

      status_word                            = '0;
      status_word[ST_EMPTY_BIT]              = empty_i;
      status_word[ST_FULL_BIT]               = full_i;
      status_word[ST_TLAST_BIT]              = tlast_detected_i;
      status_word[ST_LEVEL_LSB +: LEVEL_W]   = level_i;

      case (csr_addr_i)
         REG_CTRL:   rdata_nxt = ctrl_word;
         REG_THRESH: rdata_nxt = DATA_W'(thresh_q);
         REG_STATUS: rdata_nxt = status_word;
         REG_NWORDS: rdata_nxt = nbeats_i;
         REG_DATA:   rdata_nxt = data_rd ? out_data_i : '0;
         default:    rdata_nxt = '0;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         csr_rdata_o <= '0;
      end else if (csr_ren_i) begin
         csr_rdata_o <= rdata_nxt;
      end
   end

endmodule

`default_nettype wire

/* logic/axis_in_pkg.sv */
/*
 * AXI-Stream input core shared definitions
 * Widths, FIFO depth, register map and the lane/word view of a stored word
 */
`default_nettype none

package axis_in_pkg;

   // Stream and word sizes
   localparam int TDATA_W = 8;
   localparam int DATA_W  = 32;
   localparam int LANES   = 4;
   localparam int LANE_W  = 2;

   // Word FIFO geometry
   localparam int FIFO_ADDR_W = 4;
   localparam int FIFO_DEPTH  = 1 << FIFO_ADDR_W;
   localparam int LEVEL_W     = FIFO_ADDR_W + 1;

   // Register map
   localparam int CSR_ADDR_W = 3;
   localparam logic [CSR_ADDR_W-1:0] REG_CTRL   = 3'd0;
   localparam logic [CSR_ADDR_W-1:0] REG_THRESH = 3'd1;
   localparam logic [CSR_ADDR_W-1:0] REG_STATUS = 3'd2;
   localparam logic [CSR_ADDR_W-1:0] REG_NWORDS = 3'd3;
   localparam logic [CSR_ADDR_W-1:0] REG_DATA   = 3'd4;

   // CTRL fields
   localparam int CTRL_EN_BIT   = 0;
   localparam int CTRL_MODE_BIT = 1;
   localparam int CTRL_SRST_BIT = 2;

   // STATUS fields
   localparam int ST_EMPTY_BIT = 0;
   localparam int ST_FULL_BIT  = 1;
   localparam int ST_TLAST_BIT = 2;
   localparam int ST_LEVEL_LSB = 8;

   // One stored word, seen per lane by the RAMs or whole by the output side
   typedef union packed {
      logic [LANES-1:0][TDATA_W-1:0] lane;
      logic [DATA_W-1:0]             word;
   } stream_word_u;

endpackage

`default_nettype wire

/* logic/axis_in_top.sv */
/*
 * AXI-Stream input core top level
 * Lane packer, four lane RAMs, word FIFO controller and register block
 */
`timescale 1ns/100ps
`default_nettype none

module axis_in_top (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  logic                              axis_tvalid_i,
   input  logic [axis_in_pkg::TDATA_W-1:0]    axis_tdata_i,
   input  logic                              axis_tlast_i,
   input  logic                              sys_tready_i,
   input  logic                              csr_wen_i,
   input  logic                              csr_ren_i,
   input  logic [axis_in_pkg::CSR_ADDR_W-1:0] csr_addr_i,
   input  logic [axis_in_pkg::DATA_W-1:0]     csr_wdata_i,
   output logic                              axis_tready_o,
   output logic                              sys_tvalid_o,
   output logic [axis_in_pkg::DATA_W-1:0]     sys_tdata_o,
   output logic [axis_in_pkg::DATA_W-1:0]     csr_rdata_o,
   output logic                              interrupt_o
);

   import axis_in_pkg::*;

   logic                   enable;
   logic                   stream_mode;
   logic                   soft_rst;
   logic [LANES-1:0]       lane_we;
   logic [TDATA_W-1:0]     lane_wdata;
   logic                   word_commit;
   logic                   tlast_detected;
   logic [DATA_W-1:0]      nbeats;
   logic [FIFO_ADDR_W-1:0] wr_addr;
   logic                   rd_en;
   logic [FIFO_ADDR_W-1:0] rd_addr;
   stream_word_u           rd_word;
   logic                   full;
   logic                   empty;
   logic [LEVEL_W-1:0]     level;
   logic                   out_valid;
   logic [DATA_W-1:0]      out_data;
   logic                   pop;

   axis_lane_packer u_packer (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .soft_rst_i      (soft_rst),
      .enable_i        (enable),
      .stream_mode_i   (stream_mode),
      .fifo_full_i     (full),
      .axis_tvalid_i   (axis_tvalid_i),
      .axis_tdata_i    (axis_tdata_i),
      .axis_tlast_i    (axis_tlast_i),
      .axis_tready_o   (axis_tready_o),
      .lane_we_o       (lane_we),
      .lane_wdata_o    (lane_wdata),
      .word_commit_o   (word_commit),
      .tlast_detected_o(tlast_detected),
      .nbeats_o        (nbeats)
   );

   // One RAM per byte lane, read back as a whole word
   for (genvar g = 0; g < LANES; g++) begin : gen_lane
      lane_ram u_ram (
         .clk_i    (clk_i),
         .we_i     (lane_we[g]),
         .wr_addr_i(wr_addr),
         .wr_data_i(lane_wdata),
         .rd_en_i  (rd_en),
         .rd_addr_i(rd_addr),
         .rd_data_o(rd_word.lane[g])
      );
   end

   word_fifo_ctrl u_fifo (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .soft_rst_i   (soft_rst),
      .word_commit_i(word_commit),
      .rd_word_i    (rd_word),
      .pop_i        (pop),
      .wr_addr_o    (wr_addr),
      .rd_en_o      (rd_en),
      .rd_addr_o    (rd_addr),
      .full_o       (full),
      .empty_o      (empty),
      .level_o      (level),
      .out_valid_o  (out_valid),
      .out_data_o   (out_data)
   );

   axis_in_csr u_csr (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .csr_wen_i       (csr_wen_i),
      .csr_ren_i       (csr_ren_i),
      .csr_addr_i      (csr_addr_i),
      .csr_wdata_i     (csr_wdata_i),
      .out_valid_i     (out_valid),
      .out_data_i      (out_data),
      .empty_i         (empty),
      .full_i          (full),
      .level_i         (level),
      .tlast_detected_i(tlast_detected),
      .nbeats_i        (nbeats),
      .sys_tready_i    (sys_tready_i),
      .csr_rdata_o     (csr_rdata_o),
      .enable_o        (enable),
      .stream_mode_o   (stream_mode),
      .soft_rst_o      (soft_rst),
      .pop_o           (pop),
      .sys_tvalid_o    (sys_tvalid_o),
      .sys_tdata_o     (sys_tdata_o),
      .interrupt_o     (interrupt_o)
   );

endmodule

`default_nettype wire

/* logic/axis_lane_packer.sv */
/*
 * Stream lane packer
 * Steers input beats into byte lanes, zero-pads after tlast, counts beats
 */
`timescale 1ns/100ps
`default_nettype none

module axis_lane_packer (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  logic                           soft_rst_i,
   input  logic                           enable_i,
   input  logic                           stream_mode_i,
   input  logic                           fifo_full_i,
   input  logic                           axis_tvalid_i,
   input  logic [axis_in_pkg::TDATA_W-1:0] axis_tdata_i,
   input  logic                           axis_tlast_i,
   output logic                           axis_tready_o,
   output logic [axis_in_pkg::LANES-1:0]   lane_we_o,
   output logic [axis_in_pkg::TDATA_W-1:0] lane_wdata_o,
   output logic                           word_commit_o,
   output logic                           tlast_detected_o,
   output logic [axis_in_pkg::DATA_W-1:0]  nbeats_o
);

   import axis_in_pkg::*;

   localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(LANES - 1);

   logic [LANE_W-1:0] lane_idx;
   logic              padding;
   logic              tlast_seen;
   logic [DATA_W-1:0] beat_cnt;
   logic              beat;
   logic              pad_wr;
   logic              lane_wr;

   // Input blocked after tlast in CSR mode
   assign axis_tready_o = enable_i & ~fifo_full_i & ~padding
                          & ~(~stream_mode_i & tlast_seen);

   assign beat    = axis_tvalid_i & axis_tready_o;
   // Zero fill waits for room in the FIFO
   assign pad_wr  = padding & ~fifo_full_i;
   assign lane_wr = beat | pad_wr;

   always_comb begin
      lane_we_o = '0;
      if (lane_wr) begin
         lane_we_o[lane_idx] = 1'b1;
      end
   end

   assign lane_wdata_o  = padding ? '0 : axis_tdata_i;
   assign word_commit_o = lane_wr & (lane_idx == LAST_LANE);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         lane_idx   <= '0;
         padding    <= 1'b0;
         tlast_seen <= 1'b0;
         beat_cnt   <= '0;
      end else if (soft_rst_i) begin
         lane_idx   <= '0;
         padding    <= 1'b0;
         tlast_seen <= 1'b0;
         beat_cnt   <= '0;
      end else begin
         if (lane_wr) begin
            lane_idx <= lane_idx + 1'b1;
         end

         // tlast short of the top lane starts the fill
         if (beat && axis_tlast_i && lane_idx != LAST_LANE) begin
            padding <= 1'b1;
         end else if (pad_wr && lane_idx == LAST_LANE) begin
            padding <= 1'b0;
         end

         if (beat && axis_tlast_i) begin
            tlast_seen <= 1'b1;
         end

         // The tlast beat still counts, later beats do not
         if (beat && !tlast_seen) begin
            beat_cnt <= beat_cnt + DATA_W'(1);
         end
      end
   end

   assign tlast_detected_o = tlast_seen;
   assign nbeats_o         = beat_cnt;

endmodule

`default_nettype wire

/* logic/lane_ram.sv */
/*
 * Byte-lane RAM, one write port and one registered read port
 */
`timescale 1ns/100ps
`default_nettype none

module lane_ram (
   input  logic                               clk_i,
   input  logic                               we_i,
   input  logic [axis_in_pkg::FIFO_ADDR_W-1:0] wr_addr_i,
   input  logic [axis_in_pkg::TDATA_W-1:0]     wr_data_i,
   input  logic                               rd_en_i,
   input  logic [axis_in_pkg::FIFO_ADDR_W-1:0] rd_addr_i,
   output logic [axis_in_pkg::TDATA_W-1:0]     rd_data_o
);

   import axis_in_pkg::*;

   logic [TDATA_W-1:0] mem [FIFO_DEPTH];

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

`default_nettype wire

/* logic/word_fifo_ctrl.sv */
/*
 * Word FIFO controller over the lane RAMs
 * Pointers, level and flags, read issue and the output holding register
 */
`timescale 1ns/100ps
`default_nettype none

module word_fifo_ctrl (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   input  logic                               soft_rst_i,
   input  logic                               word_commit_i,
   input  axis_in_pkg::stream_word_u           rd_word_i,
   input  logic                               pop_i,
   output logic [axis_in_pkg::FIFO_ADDR_W-1:0] wr_addr_o,
   output logic                               rd_en_o,
   output logic [axis_in_pkg::FIFO_ADDR_W-1:0] rd_addr_o,
   output logic                               full_o,
   output logic                               empty_o,
   output logic [axis_in_pkg::LEVEL_W-1:0]     level_o,
   output logic                               out_valid_o,
   output logic [axis_in_pkg::DATA_W-1:0]      out_data_o
);

   import axis_in_pkg::*;

   // Pointers carry one wrap bit above the address
   logic [LEVEL_W-1:0] wr_ptr;
   logic [LEVEL_W-1:0] rd_ptr;
   logic [LEVEL_W-1:0] stored;
   logic               rd_pend;
   logic               out_valid;
   logic [DATA_W-1:0]  out_data;

   assign stored = wr_ptr - rd_ptr;

   assign wr_addr_o = wr_ptr[FIFO_ADDR_W-1:0];
   assign rd_addr_o = rd_ptr[FIFO_ADDR_W-1:0];

   // Fetch the next word once the holding register frees up
   assign rd_en_o = (stored != '0) & ~rd_pend & (~out_valid | pop_i);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         rd_pend   <= 1'b0;
         out_valid <= 1'b0;
      end else if (soft_rst_i) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         rd_pend   <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         if (word_commit_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en_o) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         rd_pend <= rd_en_o;

         // Returned RAM word lands here a cycle after the read
         if (rd_pend) begin
            out_valid <= 1'b1;
         end else if (pop_i) begin
            out_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_pend) begin
         out_data <= rd_word_i.word;
      end
   end

   assign out_valid_o = out_valid;
   assign out_data_o  = out_data;

   // Holding register excluded from full
   assign full_o = (stored == LEVEL_W'(FIFO_DEPTH));

   // A word in flight from the RAMs still counts as held
   assign empty_o = (stored == '0) & ~rd_pend & ~out_valid;
   assign level_o = stored + LEVEL_W'(rd_pend) + LEVEL_W'(out_valid);

endmodule

`default_nettype wire

/* tb/axis_in_tb.sv */
/*
 * Testbench for the AXI-Stream input core
 * Random frames checked against a packing model on the stream and register paths
 */
`timescale 1ns/100ps
`default_nettype none

module axis_in_tb;

   import axis_in_pkg::*;

   logic                  clk;
   logic                  rst_n;
   logic                  axis_tvalid;
   logic [TDATA_W-1:0]    axis_tdata;
   logic                  axis_tlast;
   logic                  axis_tready;
   logic                  sys_tready;
   logic                  sys_tvalid;
   logic [DATA_W-1:0]     sys_tdata;
   logic                  csr_wen;
   logic                  csr_ren;
   logic [CSR_ADDR_W-1:0] csr_addr;
   logic [DATA_W-1:0]     csr_wdata;
   logic [DATA_W-1:0]     csr_rdata;
   logic                  irq;

   // Packing model
   logic [DATA_W-1:0]  exp_q [$];
   logic [DATA_W-1:0]  part_word;
   int                 part_lane;
   bit                 model_tlast;
   int                 model_beats;

   logic [LEVEL_W-1:0] thresh;
   logic               irq_at_read;
   logic               st_empty;
   logic               st_full;
   logic               st_tlast;
   logic [LEVEL_W-1:0] st_level;
   int                 ready_mode = 0;
   bit                 csr_phase = 0;
   int                 wd_cycles = 0;
   int                 stream_len [12];
   int                 csr_len;

   axis_in_top i_dut (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .axis_tvalid_i(axis_tvalid),
      .axis_tdata_i (axis_tdata),
      .axis_tlast_i (axis_tlast),
      .sys_tready_i (sys_tready),
      .csr_wen_i    (csr_wen),
      .csr_ren_i    (csr_ren),
      .csr_addr_i   (csr_addr),
      .csr_wdata_i  (csr_wdata),
      .axis_tready_o(axis_tready),
      .sys_tvalid_o (sys_tvalid),
      .sys_tdata_o  (sys_tdata),
      .csr_rdata_o  (csr_rdata),
      .interrupt_o  (irq)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic stop_on_error();
      $display("Result: FAILED");
      $fatal(1, "Stopping at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic clear_model();
      exp_q.delete();
      part_word   = '0;
      part_lane   = 0;
      model_tlast = 1'b0;
      model_beats = 0;
   endtask

   // Lane 0 first and zero fill on tlast
   task automatic accept_beat(input logic [TDATA_W-1:0] d, input logic last);
      part_word[part_lane*TDATA_W +: TDATA_W] = d;
      part_lane++;
      if (!model_tlast) begin
         model_beats++;
      end
      if (last) begin
         model_tlast = 1'b1;
      end
      if (last || part_lane == LANES) begin
         exp_q.push_back(part_word);
         part_word = '0;
         part_lane = 0;
      end
   endtask

   task automatic write_reg(input logic [CSR_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      csr_wen   = 1'b1;
      csr_addr  = addr;
      csr_wdata = data;
      tick();
      csr_wen = 1'b0;
   endtask

   task automatic read_reg(input logic [CSR_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
      csr_ren  = 1'b1;
      csr_addr = addr;
      @(negedge clk);
      irq_at_read = irq;
      tick();
      csr_ren = 1'b0;
      data    = csr_rdata;
   endtask

   task automatic read_status();
      logic [DATA_W-1:0] st;
      read_reg(REG_STATUS, st);
      st_empty = st[ST_EMPTY_BIT];
      st_full  = st[ST_FULL_BIT];
      st_tlast = st[ST_TLAST_BIT];
      st_level = st[ST_LEVEL_LSB +: LEVEL_W];
      check_value("interrupt_o", 32'(irq_at_read), 32'(st_level >= thresh));
      assert (st_level <= 5'(FIFO_DEPTH + 1)) else begin
         $display("FIFO level %0d is beyond stored words plus holding register", st_level);
         stop_on_error();
      end
   endtask

   task automatic soft_reset(input logic [DATA_W-1:0] ctrl);
      write_reg(REG_CTRL, 32'h4);
      write_reg(REG_CTRL, ctrl);
      clear_model();
   endtask

   task automatic send_frame(input int len);
      int waited;
      bit done;
      for (int i = 0; i < len; i++) begin
         repeat ($urandom_range(0, 2)) tick();
         axis_tvalid = 1'b1;
         axis_tdata  = 8'($urandom);
         axis_tlast  = (i == len - 1);
         done   = 1'b0;
         waited = 0;
         while (!done) begin
            @(negedge clk);
            if (axis_tready) begin
               accept_beat(axis_tdata, axis_tlast);
               done = 1'b1;
            end
            tick();
            waited++;
            assert (waited < 1000) else begin
               $display("Input beat was not accepted in time");
               stop_on_error();
            end
         end
         axis_tvalid = 1'b0;
         axis_tlast  = 1'b0;
      end
   endtask

   // Offer beats that must be refused
   task automatic hold_refused(input int cycles);
      axis_tvalid = 1'b1;
      axis_tdata  = 8'($urandom);
      repeat (cycles) begin
         @(negedge clk);
         check_value("axis_tready_o", 32'(axis_tready), 32'h0);
         check_value("sys_tvalid_o", 32'(sys_tvalid), 32'h0);
         tick();
      end
      axis_tvalid = 1'b0;
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         tick();
         waited++;
         assert (waited < 2000) else begin
            $display("Output words did not drain in time");
            stop_on_error();
         end
      end
   endtask

   // Output stream side of the model
   initial begin
      logic [DATA_W-1:0] exp_w;
      forever begin
         @(negedge clk);
         if (csr_phase) begin
            check_value("sys_tvalid_o", 32'(sys_tvalid), 32'h0);
         end else if (rst_n && sys_tvalid && sys_tready) begin
            assert (exp_q.size() != 0) else begin
               $display("Output stream gave a word that the model did not expect");
               stop_on_error();
            end
            exp_w = exp_q.pop_front();
            check_value("sys_tdata_o", sys_tdata, exp_w);
         end
      end
   end

   initial begin
      forever begin
         @(posedge clk);
         #1;
         if (ready_mode == 1) begin
            sys_tready = ($urandom_range(0, 3) != 0);
         end else begin
            sys_tready = (ready_mode == 2);
         end
      end
   end

   initial begin
      wait (wd_cycles != 0);
      repeat (wd_cycles) @(posedge clk);
      $display("Run did not finish within %0d cycles", wd_cycles);
      $display("Result: FAILED");
      $fatal(1, "Watchdog timeout");
   end

   initial begin
      logic [DATA_W-1:0] data;
      logic [DATA_W-1:0] exp_w;
      int                beats;
      int                n_words;
      rst_n       = 1'b0;
      axis_tvalid = 1'b0;
      axis_tdata  = '0;
      axis_tlast  = 1'b0;
      sys_tready  = 1'b0;
      csr_wen     = 1'b0;
      csr_ren     = 1'b0;
      csr_addr    = '0;
      csr_wdata   = '0;
      void'($urandom(4482));
      clear_model();

      // First frame ends mid-word
      stream_len[0] = 4 * $urandom_range(1, 2) + $urandom_range(1, 3);
      for (int i = 1; i < 12; i++) begin
         stream_len[i] = $urandom_range(1, 13);
      end
      csr_len = $urandom_range(5, 40);
      beats   = csr_len + 150;
      foreach (stream_len[i]) begin
         beats += stream_len[i];
      end
      wd_cycles = 200 * beats + 2000;

      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      check_value("axis_tready_o", 32'(axis_tready), 32'h0);
      check_value("sys_tvalid_o", 32'(sys_tvalid), 32'h0);
      check_value("interrupt_o", 32'(irq), 32'h0);
      tick();
      thresh = 5'(FIFO_DEPTH + 1);
      write_reg(REG_THRESH, 32'(thresh));
      read_status();
      check_value("STATUS empty", 32'(st_empty), 32'h1);
      check_value("STATUS level", 32'(st_level), 32'h0);
      check_value("STATUS tlast", 32'(st_tlast), 32'h0);

      // Stream mode with enable low
      ready_mode = 2;
      write_reg(REG_CTRL, 32'h2);
      hold_refused(30);

      // Random frames under random back-pressure in stream mode
      soft_reset(32'h3);
      thresh = 5'($urandom_range(1, 6));
      write_reg(REG_THRESH, 32'(thresh));
      ready_mode = 1;
      foreach (stream_len[i]) begin
         send_frame(stream_len[i]);
         read_status();
      end
      wait_drained();
      read_status();
      check_value("STATUS empty", 32'(st_empty), 32'h1);
      check_value("STATUS tlast", 32'(st_tlast), 32'h1);
      read_reg(REG_NWORDS, data);
      check_value("NWORDS", data, 32'(model_beats));

      // Output held off until the FIFO fills
      ready_mode = 0;
      soft_reset(32'h3);
      thresh = 5'($urandom_range(10, 17));
      write_reg(REG_THRESH, 32'(thresh));
      axis_tvalid = 1'b1;
      axis_tdata  = 8'($urandom);
      repeat (100) begin
         @(negedge clk);
         if (axis_tready) begin
            accept_beat(axis_tdata, 1'b0);
            tick();
            axis_tdata = 8'($urandom);
         end else begin
            tick();
         end
      end
      axis_tvalid = 1'b0;
      read_status();
      check_value("axis_tready_o", 32'(axis_tready), 32'h0);
      check_value("STATUS full", 32'(st_full), 32'h1);
      check_value("STATUS level", 32'(st_level), 32'(exp_q.size()));
      ready_mode = 1;
      wait_drained();
      read_status();
      check_value("STATUS empty", 32'(st_empty), 32'h1);

      // One frame drained through DATA in register mode
      ready_mode = 2;
      soft_reset(32'h1);
      csr_phase = 1'b1;
      read_reg(REG_NWORDS, data);
      check_value("NWORDS", data, 32'h0);
      send_frame(csr_len);
      hold_refused(12);
      read_status();
      check_value("STATUS tlast", 32'(st_tlast), 32'h1);
      check_value("STATUS level", 32'(st_level), 32'(exp_q.size()));
      read_reg(REG_NWORDS, data);
      check_value("NWORDS", data, 32'(model_beats));
      n_words = exp_q.size();
      for (int i = 0; i < n_words; i++) begin
         read_reg(REG_DATA, data);
         exp_w = exp_q.pop_front();
         check_value("csr_rdata_o", data, exp_w);
         // Next word is back in the holding register two cycles after a pop
         repeat (2) tick();
      end
      read_status();
      check_value("STATUS empty", 32'(st_empty), 32'h1);
      soft_reset(32'h1);
      read_reg(REG_NWORDS, data);
      check_value("NWORDS", data, 32'h0);
      read_status();
      check_value("STATUS tlast", 32'(st_tlast), 32'h0);
      check_value("axis_tready_o", 32'(axis_tready), 32'h1);

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire
